//--- vlog.f
+incdir+include
verilog/cpu_pkg.sv
verilog/fetch.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/forwarding.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/data_memory.sv
verilog/cpu.sv
verif/tb_cpu.sv

//--- Makefile
TOP = tb_cpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;
  import cpu_pkg::*;

  localparam int num_tests = 12;
  localparam int program_words = 60;
  localparam int test_cycles = 200;
  localparam int clock_period = 100;
  localparam int dmem_bits = $clog2(`CPU_DMEM_WORDS);

  // instruction kinds kept next to the encoded words for the model
  localparam int k_reg = 0;
  localparam int k_imm = 1;
  localparam int k_lui = 2;
  localparam int k_auipc = 3;
  localparam int k_load = 4;
  localparam int k_store = 5;
  localparam int k_branch = 6;
  localparam int k_jal = 7;
  localparam int k_jalr = 8;
  localparam int k_halt = 9;

  logic clock = 1'b0;
  logic rst;
  logic load_enable;
  word_t load_addr;
  word_t load_data;
  logic retire_valid;
  reg_index_t retire_rd;
  word_t retire_data;
  logic store_valid;
  word_t store_addr;
  word_t store_data;

  word_t lfsr_state;
  int errors;
  int checks;
  int cycles_out;

  word_t prog_word [program_words + 2];
  int kind [program_words];
  logic [2:0] funct3 [program_words];
  logic alt [program_words];
  reg_index_t rd_of [program_words];
  reg_index_t rs1_of [program_words];
  reg_index_t rs2_of [program_words];
  word_t imm_of [program_words];

  reg_index_t exp_rd [$];
  word_t exp_data [$];
  word_t exp_addr [$];
  word_t exp_store [$];

  cpu dut (
    .clock(clock),
    .rst(rst),
    .load_enable(load_enable),
    .load_addr(load_addr),
    .load_data(load_data),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .store_valid(store_valid),
    .store_addr(store_addr),
    .store_data(store_data)
  );

  always #(clock_period / 2) clock = ~clock;

  function automatic word_t lfsr_next(input word_t s);
    lfsr_next = (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0000_0000);
  endfunction

  // one lfsr step per returned bit
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    rand_bits = v;
  endfunction

  // small register pool x0..x7 keeps dependencies dense
  function automatic reg_index_t pick_reg();
    word_t v;
    v = rand_bits(3);
    pick_reg = v[4:0];
  endfunction

  function automatic word_t sext12(input word_t v);
    sext12 = {{20{v[11]}}, v[11:0]};
  endfunction

  task automatic check(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic set_instr(input int i, input int k, input logic [2:0] f3, input logic a,
                           input reg_index_t d, input reg_index_t s1, input reg_index_t s2,
                           input word_t imm);
    kind[i] = k;
    funct3[i] = f3;
    alt[i] = a;
    rd_of[i] = d;
    rs1_of[i] = s1;
    rs2_of[i] = s2;
    imm_of[i] = imm;
  endtask

  function automatic word_t encode(input int i);
    word_t m;
    m = imm_of[i];
    case (kind[i])
      k_reg: encode = {alt[i] ? 7'b0100000 : 7'b0000000, rs2_of[i], rs1_of[i], funct3[i],
                       rd_of[i], 7'b0110011};
      k_imm: encode = {m[11:0], rs1_of[i], funct3[i], rd_of[i], 7'b0010011};
      k_lui: encode = {m[31:12], rd_of[i], 7'b0110111};
      k_auipc: encode = {m[31:12], rd_of[i], 7'b0010111};
      k_load: encode = {m[11:0], rs1_of[i], 3'b010, rd_of[i], 7'b0000011};
      k_store: encode = {m[11:5], rs2_of[i], rs1_of[i], 3'b010, m[4:0], 7'b0100011};
      k_branch: encode = {m[12], m[10:5], rs2_of[i], rs1_of[i], funct3[i], m[4:1], m[11],
                          7'b1100011};
      k_jalr: encode = {m[11:0], rs1_of[i], 3'b000, rd_of[i], 7'b1100111};
      // jal, and the final jump to itself
      default: encode = {m[20], m[10:1], m[11], m[19:12], rd_of[i], 7'b1101111};
    endcase
  endfunction

  task automatic build_program(input logic chained);
    word_t f;
    word_t a;
    word_t c;
    word_t v;
    word_t u;
    word_t s;
    word_t pick;
    reg_index_t rd;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t last_rd;
    logic reg_alt;
    logic imm_alt;
    int skip;
    last_rd = '0;
    // known values in x1..x7, then the data base address in x31
    for (int r = 1; r < 8; r++) begin
      v = rand_bits(12);
      set_instr(r - 1, k_imm, 3'd0, 1'b0, reg_index_t'(r), 5'd0, 5'd0, sext12(v));
    end
    set_instr(7, k_lui, 3'd0, 1'b0, 5'd31, 5'd0, 5'd0, '0);
    v = rand_bits(8) % 32'd252;
    set_instr(8, k_imm, 3'd0, 1'b0, 5'd31, 5'd31, 5'd0, v << 2);
    // four-word window that every later load reads from
    for (int w = 0; w < 4; w++) begin
      set_instr(9 + w, k_store, 3'd2, 1'b0, 5'd0, 5'd31, reg_index_t'(w + 1), word_t'(w * 4));
    end
    for (int i = 13; i < program_words - 1; i++) begin
      f = rand_bits(3);
      a = rand_bits(1);
      c = rand_bits(1);
      v = rand_bits(12);
      u = rand_bits(20);
      s = rand_bits(2);
      pick = rand_bits(4);
      rd = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      if (chained && c[0]) begin
        rs1 = last_rd;
      end
      // forward only and never past the final jump
      skip = (int'(s) < program_words - 2 - i) ? int'(s) : program_words - 2 - i;
      reg_alt = a[0] && (f[2:0] == 3'd0 || f[2:0] == 3'd5);
      imm_alt = a[0] && f[2:0] == 3'd5;
      case (pick[3:0])
        4'd0, 4'd1, 4'd2, 4'd3: set_instr(i, k_reg, f[2:0], reg_alt, rd, rs1, rs2, '0);
        4'd4, 4'd5, 4'd6: begin
          if (f[1:0] == 2'b01) begin
            set_instr(i, k_imm, f[2:0], imm_alt, rd, rs1, 5'd0,
                      {20'b0, 1'b0, imm_alt, 5'b0, v[4:0]});
          end else begin
            set_instr(i, k_imm, f[2:0], 1'b0, rd, rs1, 5'd0, sext12(v));
          end
        end
        4'd7: set_instr(i, k_lui, 3'd0, 1'b0, rd, 5'd0, 5'd0, {u[19:0], 12'b0});
        4'd8: set_instr(i, k_auipc, 3'd0, 1'b0, rd, 5'd0, 5'd0, {u[19:0], 12'b0});
        4'd9, 4'd10: set_instr(i, k_load, 3'd2, 1'b0, rd, 5'd31, 5'd0, {28'b0, s[1:0], 2'b0});
        4'd11: set_instr(i, k_store, 3'd2, 1'b0, 5'd0, 5'd31, rs2, {28'b0, s[1:0], 2'b0});
        4'd12, 4'd13: set_instr(i, k_branch, {f[1], 1'b0, f[0]}, 1'b0, 5'd0, rs1, rs2,
                                word_t'((skip + 1) * 4));
        4'd14: set_instr(i, k_jal, 3'd0, 1'b0, rd, 5'd0, 5'd0, word_t'((skip + 1) * 4));
        // absolute target from x0 with bit 0 set half the time
        default: set_instr(i, k_jalr, 3'd0, 1'b0, rd, 5'd0, 5'd0,
                           word_t'((i + 1 + skip) * 4) | {31'b0, a[0]});
      endcase
      last_rd = rd_of[i];
    end
    set_instr(program_words - 1, k_halt, 3'd0, 1'b0, 5'd0, 5'd0, 5'd0, '0);
    for (int i = 0; i < program_words; i++) begin
      prog_word[i] = encode(i);
    end
    prog_word[program_words] = 32'h0000_0013;
    prog_word[program_words + 1] = 32'h0000_0013;
  endtask

  function automatic word_t isa_arith(input logic [2:0] f3, input logic sub_or_sra,
                                      input word_t a, input word_t b);
    case (f3)
      3'd0: isa_arith = sub_or_sra ? a - b : a + b;
      3'd1: isa_arith = a << b[4:0];
      3'd2: isa_arith = {31'b0, $signed(a) < $signed(b)};
      3'd3: isa_arith = {31'b0, a < b};
      3'd4: isa_arith = a ^ b;
      3'd5: begin
        if (sub_or_sra) begin
          isa_arith = $signed(a) >>> b[4:0];
        end else begin
          isa_arith = a >> b[4:0];
        end
      end
      3'd6: isa_arith = a | b;
      default: isa_arith = a & b;
    endcase
  endfunction

  // executes the program in order and queues its register writes and stores
  task automatic run_model();
    word_t regs [32];
    word_t mem [`CPU_DMEM_WORDS];
    word_t a;
    word_t b;
    word_t res;
    word_t addr;
    logic wr;
    logic taken;
    int pc;
    int next_pc;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc = 0;
    while (kind[pc] != k_halt) begin
      a = regs[rs1_of[pc]];
      b = regs[rs2_of[pc]];
      addr = a + imm_of[pc];
      res = '0;
      wr = 1'b1;
      next_pc = pc + 1;
      case (kind[pc])
        k_reg: res = isa_arith(funct3[pc], alt[pc], a, b);
        k_imm: res = isa_arith(funct3[pc], alt[pc], a, imm_of[pc]);
        k_lui: res = imm_of[pc];
        k_auipc: res = word_t'(pc * 4) + imm_of[pc];
        k_load: res = mem[addr[dmem_bits+1:2]];
        k_store: begin
          wr = 1'b0;
          mem[addr[dmem_bits+1:2]] = b;
          exp_addr.push_back(addr);
          exp_store.push_back(b);
        end
        k_branch: begin
          wr = 1'b0;
          case (funct3[pc])
            3'd0: taken = a == b;
            3'd1: taken = a != b;
            3'd4: taken = $signed(a) < $signed(b);
            default: taken = $signed(a) >= $signed(b);
          endcase
          if (taken) begin
            next_pc = pc + int'(imm_of[pc] >> 2);
          end
        end
        k_jal: begin
          res = word_t'(pc * 4 + 4);
          next_pc = pc + int'(imm_of[pc] >> 2);
        end
        default: begin
          res = word_t'(pc * 4 + 4);
          next_pc = int'((addr & ~32'd1) >> 2);
        end
      endcase
      if (wr && rd_of[pc] != 5'd0) begin
        regs[rd_of[pc]] = res;
        exp_rd.push_back(rd_of[pc]);
        exp_data.push_back(res);
      end
      pc = next_pc;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < program_words + 2; i++) begin
      @(posedge clock);
      load_enable <= 1'b1;
      load_addr <= word_t'(i);
      load_data <= prog_word[i];
    end
    @(posedge clock);
    load_enable <= 1'b0;
  endtask

  always @(negedge clock) begin
    if (rst) begin
      cycles_out = 0;
    end else begin
      cycles_out = cycles_out + 1;
    end
    // pipeline still filling after reset
    if (cycles_out < 5) begin
      check("store_valid", word_t'(store_valid), '0);
      check("retire_valid", word_t'(retire_valid), '0);
    end
    if (retire_valid) begin
      if (exp_rd.size() == 0) begin
        errors++;
        $display("unexpected register write to x%0d at %0t", retire_rd, $time);
      end else begin
        check("retire_rd", word_t'(retire_rd), word_t'(exp_rd.pop_front()));
        check("retire_data", retire_data, exp_data.pop_front());
      end
    end
    if (store_valid) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("unexpected store to %h at %0t", store_addr, $time);
      end else begin
        check("store_addr", store_addr, exp_addr.pop_front());
        check("store_data", store_data, exp_store.pop_front());
      end
    end
  end

  initial begin
    #(num_tests * test_cycles * clock_period);
    $display("timeout: the tests did not finish within %0d cycles", num_tests * test_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int writes;
    int stores;
    int errors_before;
    int waited;
    lfsr_state = 32'h8499;
    errors = 0;
    checks = 0;
    cycles_out = 0;
    rst = 1'b1;
    load_enable = 1'b0;
    load_addr = '0;
    load_data = '0;
    for (int t = 0; t < num_tests; t++) begin
      build_program(t % 2 == 1);
      run_model();
      writes = exp_rd.size();
      stores = exp_addr.size();
      errors_before = errors;
      load_program();
      repeat (4) @(posedge clock);
      rst <= 1'b0;
      waited = 0;
      while ((exp_rd.size() > 0 || exp_addr.size() > 0) && waited < test_cycles) begin
        @(posedge clock);
        waited++;
      end
      // only the closing jump runs now, so any further write is unexpected
      repeat (8) @(posedge clock);
      if (exp_rd.size() > 0 || exp_addr.size() > 0) begin
        errors++;
        $display("test %0d: %0d register writes and %0d stores never appeared", t,
                 exp_rd.size(), exp_addr.size());
        exp_rd.delete();
        exp_data.delete();
        exp_addr.delete();
        exp_store.delete();
      end
      $display("test %0d (%s): %0d writes, %0d stores, %0d errors", t,
               (t % 2 == 1) ? "chained" : "random", writes, stores, errors - errors_before);
      @(posedge clock);
      rst <= 1'b1;
    end
    $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verilog/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                clock,
  input  logic                rst,
  input  logic                load_enable,
  input  cpu_pkg::word_t      load_addr,
  input  cpu_pkg::word_t      load_data,
  output logic                retire_valid,
  output cpu_pkg::reg_index_t retire_rd,
  output cpu_pkg::word_t      retire_data,
  output logic                store_valid,
  output cpu_pkg::word_t      store_addr,
  output cpu_pkg::word_t      store_data
);
  import cpu_pkg::*;

  if_id_t if_id;
  id_ex_t id_ex;
  id_ex_t id_ex_next;
  ex_mem_t ex_mem;
  ex_mem_t ex_mem_next;
  mem_wb_t mem_wb;
  mem_wb_t mem_wb_next;

  // decode
  reg_index_t id_rs1;
  reg_index_t id_rs2;
  reg_index_t id_rd;
  word_t id_immediate;
  ctrl_t id_ctrl;
  word_t id_rs1_data;
  word_t id_rs2_data;

  // execute
  word_t ex_operand_a;
  word_t ex_operand_b;
  word_t ex_store_value;
  word_t ex_alu_result;
  word_t ex_result;
  logic ex_is_jump;
  logic branch_taken;
  word_t branch_target;

  // memory and write-back
  word_t mem_load_data;
  logic wb_write;

  fetch fetch (
    .clock(clock),
    .rst(rst),
    .load_enable(load_enable),
    .load_addr(load_addr),
    .load_data(load_data),
    .redirect(branch_taken),
    .redirect_pc(branch_target),
    .fetched(if_id)
  );

  decoder decoder (
    .instruction(if_id.instruction),
    .rs1(id_rs1),
    .rs2(id_rs2),
    .rd(id_rd),
    .immediate(id_immediate),
    .ctrl(id_ctrl)
  );

  register_file register_file (
    .clock(clock),
    .rs1(id_rs1),
    .rs2(id_rs2),
    .rs1_data(id_rs1_data),
    .rs2_data(id_rs2_data),
    .write_enable(wb_write),
    .write_rd(mem_wb.rd),
    .write_data(mem_wb.result)
  );

  // a taken branch in execute squashes the instruction in decode
  assign id_ex_next = '{
    valid: if_id.valid && !branch_taken,
    pc: if_id.pc,
    rs1: id_rs1,
    rs2: id_rs2,
    rd: id_rd,
    rs1_data: id_rs1_data,
    rs2_data: id_rs2_data,
    immediate: id_immediate,
    ctrl: id_ctrl
  };

  forwarding forwarding (
    .ex(id_ex),
    .mem(ex_mem),
    .mem_load_data(mem_load_data),
    .wb(mem_wb),
    .operand_a(ex_operand_a),
    .operand_b(ex_operand_b),
    .store_value(ex_store_value)
  );

  alu alu (
    .a(ex_operand_a),
    .b(ex_operand_b),
    .op(id_ex.ctrl.alu_op),
    .result(ex_alu_result)
  );

  branch_unit branch_unit (
    .ex(id_ex),
    .rs1_value(ex_operand_a),
    .rs2_value(ex_store_value),
    .taken(branch_taken),
    .target(branch_target)
  );

  // link value for jumps
  assign ex_is_jump = (id_ex.ctrl.branch_type == branch_jal) ||
                      (id_ex.ctrl.branch_type == branch_jalr);
  assign ex_result = ex_is_jump ? id_ex.pc + 32'd4 : ex_alu_result;

  assign ex_mem_next = '{
    valid: id_ex.valid,
    result: ex_result,
    store_data: ex_store_value,
    rd: id_ex.rd,
    reg_write: id_ex.ctrl.reg_write,
    mem_read: id_ex.ctrl.mem_read,
    mem_write: id_ex.ctrl.mem_write
  };

  data_memory data_memory (
    .clock(clock),
    .address(ex_mem.result),
    .write_enable(store_valid),
    .write_data(ex_mem.store_data),
    .read_data(mem_load_data)
  );

  // load data joins the result here, write-back carries one value
  assign mem_wb_next = '{
    valid: ex_mem.valid,
    result: ex_mem.mem_read ? mem_load_data : ex_mem.result,
    rd: ex_mem.rd,
    reg_write: ex_mem.reg_write
  };

  always_ff @(posedge clock) begin
    id_ex <= id_ex_next;
    ex_mem <= ex_mem_next;
    mem_wb <= mem_wb_next;
    if (rst) begin
      id_ex.valid <= 1'b0;
      ex_mem.valid <= 1'b0;
      mem_wb.valid <= 1'b0;
    end
  end

  assign wb_write = mem_wb.valid && mem_wb.reg_write;

  // observation ports
  assign retire_valid = wb_write && mem_wb.rd != '0;
  assign retire_rd = mem_wb.rd;
  assign retire_data = mem_wb.result;
  assign store_valid = ex_mem.valid && ex_mem.mem_write;
  assign store_addr = ex_mem.result;
  assign store_data = ex_mem.store_data;

endmodule

//--- verilog/data_memory.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module data_memory (
  input  logic           clock,
  input  cpu_pkg::word_t address,
  input  logic           write_enable,
  input  cpu_pkg::word_t write_data,
  output cpu_pkg::word_t read_data
);
  import cpu_pkg::*;

  localparam int unsigned index_bits = $clog2(`CPU_DMEM_WORDS);

  word_t words [`CPU_DMEM_WORDS];
  logic [index_bits-1:0] index;

  // word addressed, byte offset ignored
  assign index = address[index_bits+1:2];

  always_ff @(posedge clock) begin
    if (write_enable) begin
      words[index] <= write_data;
    end
  end

  assign read_data = words[index];

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  cpu_pkg::id_ex_t ex,
  input  cpu_pkg::word_t  rs1_value,
  input  cpu_pkg::word_t  rs2_value,
  output logic            taken,
  output cpu_pkg::word_t  target
);
  import cpu_pkg::*;

  word_t jalr_sum;

  always_comb begin
    taken = 1'b0;
    if (ex.valid) begin
      case (ex.ctrl.branch_type)
        branch_beq: taken = (rs1_value == rs2_value);
        branch_bne: taken = (rs1_value != rs2_value);
        branch_blt: taken = ($signed(rs1_value) < $signed(rs2_value));
        branch_bge: taken = ($signed(rs1_value) >= $signed(rs2_value));
        branch_jal: taken = 1'b1;
        branch_jalr: taken = 1'b1;
        default: taken = 1'b0;
      endcase
    end
  end

  // jalr drops bit 0 of the sum
  assign jalr_sum = rs1_value + ex.immediate;
  assign target = (ex.ctrl.branch_type == branch_jalr) ? {jalr_sum[31:1], 1'b0} :
                  ex.pc + ex.immediate;

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_t op,
  output cpu_pkg::word_t   result
);
  import cpu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_sll: result = a << shamt;
      alu_slt: result = {31'b0, $signed(a) < $signed(b)};
      alu_sltu: result = {31'b0, a < b};
      alu_xor: result = a ^ b;
      alu_srl: result = a >> shamt;
      alu_sra: result = word_t'($signed(a) >>> shamt);
      alu_or: result = a | b;
      alu_and: result = a & b;
      // lui, immediate already shifted up
      alu_pass_b: result = b;
      default: result = a + b;
    endcase
  end

endmodule

//--- verilog/forwarding.sv
`timescale 1ns/1ps

module forwarding (
  input  cpu_pkg::id_ex_t  ex,
  input  cpu_pkg::ex_mem_t mem,
  input  cpu_pkg::word_t   mem_load_data,
  input  cpu_pkg::mem_wb_t wb,
  output cpu_pkg::word_t   operand_a,
  output cpu_pkg::word_t   operand_b,
  output cpu_pkg::word_t   store_value
);
  import cpu_pkg::*;

  word_t mem_value;
  word_t rs1_value;
  word_t rs2_value;
  logic mem_source;
  logic wb_source;

  // a load in the memory stage forwards its data directly
  assign mem_value = mem.mem_read ? mem_load_data : mem.result;
  assign mem_source = mem.valid && mem.reg_write && mem.rd != '0;
  assign wb_source = wb.valid && wb.reg_write && wb.rd != '0;

  // younger producer wins
  assign rs1_value = (mem_source && mem.rd == ex.rs1) ? mem_value :
                     (wb_source && wb.rd == ex.rs1) ? wb.result : ex.rs1_data;
  assign rs2_value = (mem_source && mem.rd == ex.rs2) ? mem_value :
                     (wb_source && wb.rd == ex.rs2) ? wb.result : ex.rs2_data;

  assign operand_a = ex.ctrl.use_pc ? ex.pc : rs1_value;
  assign operand_b = ex.ctrl.use_rs2 ? rs2_value : ex.immediate;
  assign store_value = rs2_value;

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                clock,
  input  cpu_pkg::reg_index_t rs1,
  input  cpu_pkg::reg_index_t rs2,
  output cpu_pkg::word_t      rs1_data,
  output cpu_pkg::word_t      rs2_data,
  input  logic                write_enable,
  input  cpu_pkg::reg_index_t write_rd,
  input  cpu_pkg::word_t      write_data
);
  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (write_enable && write_rd != '0) begin
      regs[write_rd] <= write_data;
    end
  end

  // x0 reads zero, a same-cycle write shows through to decode
  assign rs1_data = (rs1 == '0) ? '0 :
                    (write_enable && write_rd == rs1) ? write_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (write_enable && write_rd == rs2) ? write_data : regs[rs2];

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  cpu_pkg::word_t      instruction,
  output cpu_pkg::reg_index_t rs1,
  output cpu_pkg::reg_index_t rs2,
  output cpu_pkg::reg_index_t rd,
  output cpu_pkg::word_t      immediate,
  output cpu_pkg::ctrl_t      ctrl
);
  import cpu_pkg::*;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic imm_funct_ok;
  logic reg_funct_ok;
  logic shift_alt;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  // shared by register and immediate forms
  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: arith_op = alt ? alu_sub : alu_add;
      3'b001: arith_op = alu_sll;
      3'b010: arith_op = alu_slt;
      3'b011: arith_op = alu_sltu;
      3'b100: arith_op = alu_xor;
      3'b101: arith_op = alt ? alu_sra : alu_srl;
      3'b110: arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];
  assign rd = instruction[11:7];
  assign rs1 = instruction[19:15];
  assign rs2 = instruction[24:20];

  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};
  assign imm_u = {instruction[31:12], 12'b0};
  assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};

  // bit 30 only selects sub/sra, everywhere else funct7 must be zero
  assign imm_funct_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                        (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                        1'b1;
  assign reg_funct_ok = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign shift_alt = (funct3 == 3'b101) && funct7[5];

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    ctrl.branch_type = branch_none;
    immediate = imm_i;
    case (opcode)
      op_lui: begin
        ctrl.alu_op = alu_pass_b;
        ctrl.reg_write = 1'b1;
        immediate = imm_u;
      end
      op_auipc: begin
        ctrl.use_pc = 1'b1;
        ctrl.reg_write = 1'b1;
        immediate = imm_u;
      end
      op_jal: begin
        ctrl.use_pc = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.branch_type = branch_jal;
        immediate = imm_j;
      end
      // jalr adds to rs1, so operand a stays the register
      op_jalr: begin
        if (funct3 == 3'b000) begin
          ctrl.reg_write = 1'b1;
          ctrl.branch_type = branch_jalr;
        end
      end
      op_branch: begin
        ctrl.use_rs2 = 1'b1;
        immediate = imm_b;
        case (funct3)
          3'b000: ctrl.branch_type = branch_beq;
          3'b001: ctrl.branch_type = branch_bne;
          3'b100: ctrl.branch_type = branch_blt;
          3'b101: ctrl.branch_type = branch_bge;
          default: ctrl.branch_type = branch_none;
        endcase
      end
      op_load: begin
        if (funct3 == 3'b010) begin
          ctrl.mem_read = 1'b1;
          ctrl.reg_write = 1'b1;
        end
      end
      op_store: begin
        immediate = imm_s;
        if (funct3 == 3'b010) begin
          ctrl.mem_write = 1'b1;
        end
      end
      op_imm: begin
        if (imm_funct_ok) begin
          ctrl.alu_op = arith_op(funct3, shift_alt);
          ctrl.reg_write = 1'b1;
        end
      end
      op_reg: begin
        if (reg_funct_ok) begin
          ctrl.alu_op = arith_op(funct3, funct7[5]);
          ctrl.use_rs2 = 1'b1;
          ctrl.reg_write = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/fetch.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch (
  input  logic            clock,
  input  logic            rst,
  input  logic            load_enable,
  input  cpu_pkg::word_t  load_addr,
  input  cpu_pkg::word_t  load_data,
  input  logic            redirect,
  input  cpu_pkg::word_t  redirect_pc,
  output cpu_pkg::if_id_t fetched
);
  import cpu_pkg::*;

  localparam int unsigned index_bits = $clog2(`CPU_IMEM_WORDS);

  word_t imem [`CPU_IMEM_WORDS];
  word_t pc;
  word_t next_pc;

  assign next_pc = redirect ? redirect_pc : pc + 32'd4;

  // program load, only while the core is held in reset
  always_ff @(posedge clock) begin
    if (rst && load_enable) begin
      imem[load_addr[index_bits-1:0]] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= `CPU_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // the word fetched on a redirect edge is wrong-path, so it goes in as a bubble
  always_ff @(posedge clock) begin
    fetched.pc <= pc;
    fetched.instruction <= imem[pc[index_bits+1:2]];
    if (rst || redirect) begin
      fetched.valid <= 1'b0;
    end else begin
      fetched.valid <= 1'b1;
    end
  end

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_index_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    branch_none,
    branch_beq,
    branch_bne,
    branch_blt,
    branch_bge,
    branch_jal,
    branch_jalr
  } branch_type_t;

  // decoded control, travels with the instruction into execute
  typedef struct packed {
    alu_op_t alu_op;
    logic use_rs2;
    logic use_pc;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    branch_type_t branch_type;
  } ctrl_t;

  typedef struct packed {
    logic valid;
    word_t pc;
    word_t instruction;
  } if_id_t;

  typedef struct packed {
    logic valid;
    word_t pc;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t rd;
    word_t rs1_data;
    word_t rs2_data;
    word_t immediate;
    ctrl_t ctrl;
  } id_ex_t;

  typedef struct packed {
    logic valid;
    word_t result;
    word_t store_data;
    reg_index_t rd;
    logic reg_write;
    logic mem_read;
    logic mem_write;
  } ex_mem_t;

  // result already holds load data for loads
  typedef struct packed {
    logic valid;
    word_t result;
    reg_index_t rd;
    logic reg_write;
  } mem_wb_t;

endpackage

//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction memory depth in 32-bit words
`define CPU_IMEM_WORDS 256

// data memory depth in 32-bit words
`define CPU_DMEM_WORDS 256

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif
